//--- nn_cfg_pkg.sv
`default_nettype none

package nn_cfg_pkg;

    localparam int CFG_WORD_W = 256;
    localparam int CFG_ADDR_W = 17;

    // field widths inside configuration words
    localparam int LCOUNT_W    = 11;
    localparam int NINPUTS_W   = 10;
    localparam int SHIFT_W     = 5;
    localparam int CHUNK_LANES = 8;
    localparam int CHUNK_IDX_W = 10;
    localparam int CHUNK_WGT_W = 16;

    typedef logic [CFG_ADDR_W-1:0] cfg_addr_t;

    // header word and layer entry share this layout
    typedef struct packed {
        logic [LCOUNT_W-1:0] count;
        cfg_addr_t           location;
        logic [3:0]          reserved;
    } layer_hdr_t;

    // low 128 bits of a neuron-table word
    typedef struct packed {
        logic [NINPUTS_W-1:0] ninputs;
        cfg_addr_t            lbase;
        cfg_addr_t            oloc;
        cfg_addr_t            nimap;
        cfg_addr_t            wimap;
        cfg_addr_t            neuron_table;
        logic [SHIFT_W-1:0]   neuron_shift;
        logic [SHIFT_W-1:0]   post_shift;
        logic [22:0]          unused;
    } neuron_tbl_t;

    // indices in 79:0 and weights in 223:96 with lane 0 lowest
    typedef struct packed {
        logic [31:0]                                   unused_hi;
        logic [CHUNK_LANES-1:0][CHUNK_WGT_W-1:0]       weight;
        logic [15:0]                                   unused_mid;
        logic [CHUNK_LANES-1:0][CHUNK_IDX_W-1:0]       index;
    } chunk_word_t;

endpackage

`default_nettype wire

//--- nn_operand_pkg.sv
`default_nettype none

package nn_operand_pkg;

    localparam int LANES       = nn_cfg_pkg::CHUNK_LANES;
    localparam int IN_W        = 24;
    localparam int W_W         = nn_cfg_pkg::CHUNK_WGT_W;
    localparam int DATA_ADDR_W = 17;
    localparam int INDEX_W     = nn_cfg_pkg::CHUNK_IDX_W;
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

    typedef logic [DATA_ADDR_W-1:0]            data_addr_t;
    typedef logic [LANES-1:0][DATA_ADDR_W-1:0] lane_addr_t;
    typedef logic [LANES-1:0][IN_W-1:0]        lane_in_t;
    typedef logic [LANES-1:0][W_W-1:0]         lane_wgt_t;

    typedef struct packed {
        lane_addr_t                              addr;
        lane_wgt_t                               weight;
        // remaining count before this chunk
        logic [nn_cfg_pkg::NINPUTS_W-1:0]        ninputs_left;
        nn_cfg_pkg::cfg_addr_t                   neuron_table;
        logic [nn_cfg_pkg::SHIFT_W-1:0]          neuron_shift;
        logic [nn_cfg_pkg::SHIFT_W-1:0]          post_shift;
        data_addr_t                              oloc;
        logic [nn_cfg_pkg::LCOUNT_W-1:0]         neuron_number;
    } chunk_t;

    typedef struct packed {
        lane_in_t                                inputs;
        lane_wgt_t                               weights;
        nn_cfg_pkg::cfg_addr_t                   neuron_table;
        logic [nn_cfg_pkg::SHIFT_W-1:0]          neuron_shift;
        logic [nn_cfg_pkg::SHIFT_W-1:0]          post_shift;
        data_addr_t                              oloc;
        logic [nn_cfg_pkg::NINPUTS_W-1:0]        ninputs;
        logic [nn_cfg_pkg::LCOUNT_W-1:0]         neuron_number;
    } operand_t;

endpackage

`default_nettype wire

//--- fetch_sequencer.sv
`default_nettype none

module fetch_sequencer (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              i_start,
    input  nn_cfg_pkg::cfg_addr_t             i_table_base,
    input  logic [nn_cfg_pkg::CFG_WORD_W-1:0] i_cfg_data,
    input  logic                              i_nearly_full,
    input  logic                              i_layer_done,
    output nn_cfg_pkg::cfg_addr_t             o_cfg_addr,
    output logic                              o_chunk_valid,
    output nn_operand_pkg::chunk_t            o_chunk,
    output logic                              o_finish
);

    import nn_cfg_pkg::*;
    import nn_operand_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_HDR,
        S_LAYER,
        S_NEURON,
        S_CHUNK,
        S_NEXT,
        S_LWAIT
    } state_t;

    state_t state;
    state_t state_n;

    layer_hdr_t  hdr_word;
    neuron_tbl_t tbl_word;
    chunk_word_t chunk_word;
    neuron_tbl_t tbl_q;

    cfg_addr_t layer_ptr;
    cfg_addr_t neuron_ptr;
    cfg_addr_t chunk_ptr;

    logic [LCOUNT_W-1:0]  layer_left;
    logic [LCOUNT_W-1:0]  neuron_left;
    logic [LCOUNT_W-1:0]  neuron_idx;
    logic [LCOUNT_W-1:0]  cur_number;
    logic [NINPUTS_W-1:0] rem;
    logic [NINPUTS_W-1:0] issue_left;
    logic                 issue;
    logic                 chunk_valid_q;
    logic                 finish_q;

    // header, layer entry and neuron table all sit in the low bits of the word
    assign hdr_word   = i_cfg_data[$bits(layer_hdr_t)-1:0];
    assign tbl_word   = i_cfg_data[$bits(neuron_tbl_t)-1:0];
    assign chunk_word = i_cfg_data;

    // new chunk reads only while the queue has room for the two in flight
    assign issue = (state == S_CHUNK) && (rem != '0) && !i_nearly_full;

    always_comb
    begin
        state_n    = state;
        o_cfg_addr = chunk_ptr;
        case (state)
            S_IDLE:
            begin
                o_cfg_addr = i_table_base;
                if (i_start)
                    state_n = S_HDR;
            end
            S_HDR:
            begin
                o_cfg_addr = hdr_word.location;
                state_n    = (hdr_word.count != '0) ? S_LAYER : S_IDLE;
            end
            S_LAYER:
            begin
                o_cfg_addr = hdr_word.location;
                state_n    = (hdr_word.count != '0) ? S_NEURON : S_LWAIT;
            end
            S_NEURON:
                state_n = S_CHUNK;
            S_CHUNK:
            begin
                if ((rem == '0) || (issue && (rem <= NINPUTS_W'(LANES))))
                    state_n = S_NEXT;
            end
            S_NEXT:
            begin
                o_cfg_addr = neuron_ptr;
                state_n    = (neuron_left != '0) ? S_NEURON : S_LWAIT;
            end
            S_LWAIT:
            begin
                o_cfg_addr = layer_ptr;
                if (i_layer_done)
                    state_n = (layer_left != '0) ? S_LAYER : S_IDLE;
            end
            default:
                state_n = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state         <= S_IDLE;
            chunk_valid_q <= 1'b0;
            finish_q      <= 1'b0;
            layer_ptr     <= '0;
            neuron_ptr    <= '0;
            chunk_ptr     <= '0;
            layer_left    <= '0;
            neuron_left   <= '0;
            neuron_idx    <= '0;
            rem           <= '0;
        end
        else
        begin
            state         <= state_n;
            chunk_valid_q <= issue;
            case (state)
                S_IDLE:
                begin
                    if (i_start)
                        finish_q <= 1'b0;
                end
                S_HDR:
                begin
                    layer_ptr  <= hdr_word.location + 1'b1;
                    layer_left <= hdr_word.count - 1'b1;
                    if (hdr_word.count == '0)
                        finish_q <= 1'b1;
                end
                S_LAYER:
                begin
                    neuron_ptr  <= hdr_word.location + 1'b1;
                    neuron_left <= hdr_word.count - 1'b1;
                    neuron_idx  <= '0;
                end
                S_NEURON:
                begin
                    chunk_ptr  <= tbl_word.wimap;
                    rem        <= tbl_word.ninputs;
                    neuron_idx <= neuron_idx + 1'b1;
                end
                S_CHUNK:
                begin
                    if (issue)
                    begin
                        chunk_ptr <= chunk_ptr + 1'b1;
                        rem <= (rem > NINPUTS_W'(LANES)) ? rem - NINPUTS_W'(LANES) : '0;
                    end
                end
                S_NEXT:
                begin
                    if (neuron_left != '0)
                    begin
                        neuron_ptr  <= neuron_ptr + 1'b1;
                        neuron_left <= neuron_left - 1'b1;
                    end
                end
                S_LWAIT:
                begin
                    if (i_layer_done)
                    begin
                        if (layer_left != '0)
                        begin
                            layer_ptr  <= layer_ptr + 1'b1;
                            layer_left <= layer_left - 1'b1;
                        end
                        else
                            finish_q <= 1'b1;
                    end
                end
                default:
                    finish_q <= finish_q;
            endcase
        end
    end

    // table stays put until the last chunk of the neuron has returned
    always_ff @(posedge clk)
    begin
        if (state == S_NEURON)
        begin
            tbl_q      <= tbl_word;
            cur_number <= neuron_idx;
        end
        if (issue)
            issue_left <= rem;
    end

    always_comb
    begin
        for (int l = 0; l < LANES; l++)
            o_chunk.addr[l] = tbl_q.lbase + DATA_ADDR_W'(chunk_word.index[l]);
        o_chunk.weight        = chunk_word.weight;
        o_chunk.ninputs_left  = issue_left;
        o_chunk.neuron_table  = tbl_q.neuron_table;
        o_chunk.neuron_shift  = tbl_q.neuron_shift;
        o_chunk.post_shift    = tbl_q.post_shift;
        o_chunk.oloc          = tbl_q.oloc;
        o_chunk.neuron_number = cur_number;
    end

    assign o_chunk_valid = chunk_valid_q;
    assign o_finish      = finish_q;

endmodule

`default_nettype wire

//--- operand_gather.sv
`default_nettype none

module operand_gather (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       i_chunk_valid,
    input  nn_operand_pkg::chunk_t     i_chunk,
    input  nn_operand_pkg::lane_in_t   i_data,
    output nn_operand_pkg::lane_addr_t o_data_addr,
    output logic                       o_wr,
    output nn_operand_pkg::operand_t   o_wr_data
);

    import nn_operand_pkg::*;

    chunk_t chunk_q;
    logic   valid_q;

    // data memory answers one cycle after the address
    assign o_data_addr = i_chunk.addr;
    assign o_wr        = valid_q;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            valid_q <= 1'b0;
        else
            valid_q <= i_chunk_valid;
    end

    always_ff @(posedge clk)
    begin
        if (i_chunk_valid)
            chunk_q <= i_chunk;
    end

    always_comb
    begin
        for (int l = 0; l < LANES; l++)
        begin
            // lanes past the remaining count carry nothing
            if (l < int'(chunk_q.ninputs_left))
            begin
                o_wr_data.inputs[l]  = i_data[l];
                o_wr_data.weights[l] = chunk_q.weight[l];
            end
            else
            begin
                o_wr_data.inputs[l]  = '0;
                o_wr_data.weights[l] = '0;
            end
        end
        o_wr_data.neuron_table  = chunk_q.neuron_table;
        o_wr_data.neuron_shift  = chunk_q.neuron_shift;
        o_wr_data.post_shift    = chunk_q.post_shift;
        o_wr_data.oloc          = chunk_q.oloc;
        o_wr_data.ninputs       = chunk_q.ninputs_left;
        o_wr_data.neuron_number = chunk_q.neuron_number;
    end

endmodule

`default_nettype wire

//--- operand_queue.sv
`default_nettype none

module operand_queue (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     i_wr,
    input  nn_operand_pkg::operand_t i_wr_data,
    input  logic                     i_stopin,
    output logic                     o_nearly_full,
    output logic                     o_push,
    output nn_operand_pkg::operand_t o_operand
);

    import nn_operand_pkg::*;

    operand_t               mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_CNT_W-1:0] count;
    logic                   empty;
    logic                   pop;
    logic                   store;
    operand_t               head;

    assign empty = (count == '0);
    // an empty queue hands a fresh record straight through
    assign head  = empty ? i_wr_data : mem[rd_ptr];
    assign pop   = (!empty || i_wr) && !i_stopin;
    assign store = i_wr && !(empty && pop);

    assign o_nearly_full = (count > QUEUE_CNT_W'(1));

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            o_push <= 1'b0;
        end
        else
        begin
            o_push <= pop;
            count  <= count + QUEUE_CNT_W'(i_wr) - QUEUE_CNT_W'(pop);
            if (store)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop && !empty)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (store)
            mem[wr_ptr] <= i_wr_data;
        if (pop)
            o_operand <= head;
    end

endmodule

`default_nettype wire

//--- neuron_fetch_top.sv
`default_nettype none

module neuron_fetch_top (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              i_start,
    input  nn_cfg_pkg::cfg_addr_t             i_table_base,
    output nn_cfg_pkg::cfg_addr_t             o_cfg_addr,
    input  logic [nn_cfg_pkg::CFG_WORD_W-1:0] i_cfg_data,
    output nn_operand_pkg::lane_addr_t        o_data_addr,
    input  nn_operand_pkg::lane_in_t          i_data,
    input  logic                              i_stopin,
    input  logic                              i_layer_done,
    output logic                              o_push,
    output nn_operand_pkg::operand_t          o_operand,
    output logic                              o_finish
);

    import nn_operand_pkg::*;

    logic     chunk_valid;
    chunk_t   chunk;
    logic     wr;
    operand_t wr_data;
    logic     nearly_full;

    fetch_sequencer u_sequencer (
        .clk           (clk),
        .reset         (reset),
        .i_start       (i_start),
        .i_table_base  (i_table_base),
        .i_cfg_data    (i_cfg_data),
        .i_nearly_full (nearly_full),
        .i_layer_done  (i_layer_done),
        .o_cfg_addr    (o_cfg_addr),
        .o_chunk_valid (chunk_valid),
        .o_chunk       (chunk),
        .o_finish      (o_finish)
    );

    operand_gather u_gather (
        .clk           (clk),
        .reset         (reset),
        .i_chunk_valid (chunk_valid),
        .i_chunk       (chunk),
        .i_data        (i_data),
        .o_data_addr   (o_data_addr),
        .o_wr          (wr),
        .o_wr_data     (wr_data)
    );

    operand_queue u_queue (
        .clk           (clk),
        .reset         (reset),
        .i_wr          (wr),
        .i_wr_data     (wr_data),
        .i_stopin      (i_stopin),
        .o_nearly_full (nearly_full),
        .o_push        (o_push),
        .o_operand     (o_operand)
    );

endmodule

`default_nettype wire

//--- tb_operand_checker.sv
`default_nettype none

module tb_operand_checker (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     i_push,
    input  nn_operand_pkg::operand_t i_operand,
    input  logic                     i_stopin,
    output int                       o_seen,
    output int                       o_errors,
    output int                       o_pending
);

    import nn_operand_pkg::*;

    operand_t expect_q [$];
    operand_t want;
    logic     stalled_q;

    initial
    begin
        o_seen    = 0;
        o_errors  = 0;
        o_pending = 0;
        stalled_q = 1'b0;
    end

    task automatic add_expected(input operand_t rec);
        expect_q.push_back(rec);
        o_pending = expect_q.size();
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp_val);
        if (got !== exp_val)
        begin
            o_errors = o_errors + 1;
            $display("[ERROR] %0t: record %0d %s is %h, expected %h",
                     $time, o_seen, name, got, exp_val);
        end
    endtask

    task automatic compare_record(input operand_t got, input operand_t exp_rec);
        for (int l = 0; l < LANES; l++)
        begin
            compare_field($sformatf("input %0d", l), got.inputs[l], exp_rec.inputs[l]);
            compare_field($sformatf("weight %0d", l), got.weights[l], exp_rec.weights[l]);
        end
        compare_field("neuron_table", got.neuron_table, exp_rec.neuron_table);
        compare_field("neuron_shift", got.neuron_shift, exp_rec.neuron_shift);
        compare_field("post_shift", got.post_shift, exp_rec.post_shift);
        compare_field("oloc", got.oloc, exp_rec.oloc);
        compare_field("ninputs", got.ninputs, exp_rec.ninputs);
        compare_field("neuron_number", got.neuron_number, exp_rec.neuron_number);
    endtask

    // o_push is registered, so it answers the stopin level of the cycle before
    always @(posedge clk)
    begin
        if (!reset && i_push)
        begin
            if (stalled_q)
            begin
                o_errors = o_errors + 1;
                $display("[ERROR] %0t: o_push came right after a cycle with i_stopin high",
                         $time);
            end
            if (expect_q.size() == 0)
            begin
                o_errors = o_errors + 1;
                $display("[ERROR] %0t: a record was pushed while none was expected", $time);
            end
            else
            begin
                want = expect_q.pop_front();
                compare_record(i_operand, want);
            end
            o_seen    = o_seen + 1;
            o_pending = expect_q.size();
        end
        stalled_q = i_stopin;
    end

endmodule

`default_nettype wire

//--- tb_neuron_fetch.sv
`default_nettype none

module tb_neuron_fetch;

    import nn_cfg_pkg::*;
    import nn_operand_pkg::*;

    localparam logic [31:0] SEED       = 32'h97b4_61fd;
    localparam int          WAIT_LIMIT = 4000;

    logic                  clk;
    logic                  reset;
    logic                  i_start;
    cfg_addr_t             i_table_base;
    cfg_addr_t             o_cfg_addr;
    logic [CFG_WORD_W-1:0] i_cfg_data;
    lane_addr_t            o_data_addr;
    lane_in_t              i_data;
    logic                  i_stopin;
    logic                  i_layer_done;
    logic                  o_push;
    operand_t              o_operand;
    logic                  o_finish;

    int          seen;
    int          chk_errors;
    int          pending;
    int          run_errors;
    int          timeouts;
    logic [31:0] rng;
    logic [31:0] stall_rng;
    logic        stall_on;

    logic [CFG_WORD_W-1:0] cmem [cfg_addr_t];
    logic [IN_W-1:0]       dmem [0:2**DATA_ADDR_W-1];
    int                    n_layers;
    int                    n_neurons [3];
    int                    n_inputs [3][4];

    neuron_fetch_top uut (
        .clk          (clk),
        .reset        (reset),
        .i_start      (i_start),
        .i_table_base (i_table_base),
        .o_cfg_addr   (o_cfg_addr),
        .i_cfg_data   (i_cfg_data),
        .o_data_addr  (o_data_addr),
        .i_data       (i_data),
        .i_stopin     (i_stopin),
        .i_layer_done (i_layer_done),
        .o_push       (o_push),
        .o_operand    (o_operand),
        .o_finish     (o_finish)
    );

    tb_operand_checker u_checker (
        .clk       (clk),
        .reset     (reset),
        .i_push    (o_push),
        .i_operand (o_operand),
        .i_stopin  (i_stopin),
        .o_seen    (seen),
        .o_errors  (chk_errors),
        .o_pending (pending)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = lcg_step(rng);
        return rng;
    endfunction

    function automatic int rand_below(input int n);
        return int'((next_rand() >> 8) % n);
    endfunction

    function automatic logic [CFG_WORD_W-1:0] rand_word();
        logic [CFG_WORD_W-1:0] w;
        for (int i = 0; i < CFG_WORD_W / 32; i++)
            w[i*32 +: 32] = next_rand();
        return w;
    endfunction

    function automatic int chunks_of(input int n);
        return (n + LANES - 1) / LANES;
    endfunction

    function automatic lane_in_t read_lanes(input lane_addr_t a);
        lane_in_t d;
        for (int l = 0; l < LANES; l++)
            d[l] = dmem[a[l]];
        return d;
    endfunction

    // both memories answer one cycle after the address
    always @(posedge clk)
    begin
        i_cfg_data <= #1 cmem.exists(o_cfg_addr) ? cmem[o_cfg_addr] : '0;
        i_data     <= #1 read_lanes(o_data_addr);
    end

    always
    begin
        @(posedge clk);
        #1;
        stall_rng = lcg_step(stall_rng);
        i_stopin  = stall_on && (stall_rng[31:24] < 8'd102);
    end

    // header or layer entry with random bits outside the used fields
    function automatic logic [CFG_WORD_W-1:0] hdr_word(input int count, input cfg_addr_t loc);
        logic [CFG_WORD_W-1:0] w;
        layer_hdr_t            h;
        w          = rand_word();
        h          = w[$bits(layer_hdr_t)-1:0];
        h.count    = LCOUNT_W'(count);
        h.location = loc;
        w[$bits(layer_hdr_t)-1:0] = h;
        return w;
    endfunction

    task automatic build_tables(input cfg_addr_t base);
        logic [CFG_WORD_W-1:0] w;
        neuron_tbl_t           tbl;
        cfg_addr_t             ptr;
        cfg_addr_t             ntab [3];
        n_layers   = 2 + rand_below(2);
        cmem[base] = hdr_word(n_layers, base + 1'b1);
        ptr        = base + cfg_addr_t'(1 + n_layers);
        for (int l = 0; l < n_layers; l++)
        begin
            n_neurons[l] = (l == 0) ? 2 + rand_below(3) : 1 + rand_below(4);
            ntab[l]      = ptr;
            ptr          = ptr + cfg_addr_t'(n_neurons[l]);
            cmem[base + cfg_addr_t'(1 + l)] = hdr_word(n_neurons[l], ntab[l]);
        end
        for (int l = 0; l < n_layers; l++)
        begin
            for (int n = 0; n < n_neurons[l]; n++)
            begin
                // first neurons of layers 0 and 1 take exactly one and two chunks
                // second neuron of layer 0 ends on a partial chunk
                if (n == 0 && l < 2)
                    n_inputs[l][n] = 8 * (l + 1);
                else if (n == 1 && l == 0)
                    n_inputs[l][n] = 8 * rand_below(3) + 1 + rand_below(7);
                else
                    n_inputs[l][n] = 1 + rand_below(30);
                w           = rand_word();
                tbl         = w[$bits(neuron_tbl_t)-1:0];
                tbl.ninputs = NINPUTS_W'(n_inputs[l][n]);
                tbl.wimap   = ptr;
                w[$bits(neuron_tbl_t)-1:0] = tbl;
                cmem[ntab[l] + cfg_addr_t'(n)] = w;
                for (int c = 0; c < chunks_of(n_inputs[l][n]); c++)
                begin
                    cmem[ptr] = rand_word();
                    ptr       = ptr + 1'b1;
                end
            end
        end
    endtask

    // expected record decoded from the tables in configuration memory
    function automatic operand_t expected_operand(input cfg_addr_t base, input int layer,
                                                  input int neuron, input int chunk);
        layer_hdr_t  hdr;
        layer_hdr_t  entry;
        neuron_tbl_t tbl;
        chunk_word_t cw;
        operand_t    r;
        data_addr_t  a;
        int          left;
        hdr   = cmem[base][$bits(layer_hdr_t)-1:0];
        entry = cmem[hdr.location + cfg_addr_t'(layer)][$bits(layer_hdr_t)-1:0];
        tbl   = cmem[entry.location + cfg_addr_t'(neuron)][$bits(neuron_tbl_t)-1:0];
        cw    = cmem[tbl.wimap + cfg_addr_t'(chunk)];
        left  = int'(tbl.ninputs) - LANES * chunk;
        for (int l = 0; l < LANES; l++)
        begin
            a            = tbl.lbase + data_addr_t'(cw.index[l]);
            r.inputs[l]  = (l < left) ? dmem[a] : '0;
            r.weights[l] = (l < left) ? cw.weight[l] : '0;
        end
        r.neuron_table  = tbl.neuron_table;
        r.neuron_shift  = tbl.neuron_shift;
        r.post_shift    = tbl.post_shift;
        r.oloc          = tbl.oloc;
        r.ninputs       = NINPUTS_W'(left);
        r.neuron_number = LCOUNT_W'(neuron);
        return r;
    endfunction

    function automatic int layer_chunks(input int layer);
        int total;
        total = 0;
        for (int n = 0; n < n_neurons[layer]; n++)
            total = total + chunks_of(n_inputs[layer][n]);
        return total;
    endfunction

    task automatic queue_layer(input cfg_addr_t base, input int layer);
        for (int n = 0; n < n_neurons[layer]; n++)
            for (int c = 0; c < chunks_of(n_inputs[layer][n]); c++)
                u_checker.add_expected(expected_operand(base, layer, n, c));
    endtask

    task automatic wait_records(input int target);
        int n;
        n = 0;
        while (seen < target && n < WAIT_LIMIT)
        begin
            @(posedge clk);
            #1;
            n = n + 1;
            if (o_finish)
            begin
                run_errors = run_errors + 1;
                $display("[ERROR] %0t: o_finish is high before the last layer-done", $time);
            end
        end
        if (seen < target)
        begin
            timeouts = timeouts + 1;
            $display("timeout: only %0d of %0d records arrived", seen, target);
        end
    endtask

    task automatic wait_finish(input logic level);
        int n;
        n = 0;
        while (o_finish !== level && n < WAIT_LIMIT)
        begin
            @(posedge clk);
            #1;
            n = n + 1;
        end
        if (o_finish !== level)
        begin
            timeouts = timeouts + 1;
            $display("timeout: o_finish never went to %b", level);
        end
    endtask

    task automatic run_tables(input cfg_addr_t base);
        int target;
        build_tables(base);
        target = seen;
        queue_layer(base, 0);
        i_table_base = base;
        i_start      = 1'b1;
        @(posedge clk);
        #1;
        i_start = 1'b0;
        wait_finish(1'b0);
        for (int l = 0; l < n_layers && timeouts == 0; l++)
        begin
            target = target + layer_chunks(l);
            wait_records(target);
            // next layer becomes legal only with this layer-done
            if (l + 1 < n_layers)
                queue_layer(base, l + 1);
            i_layer_done = 1'b1;
            @(posedge clk);
            #1;
            i_layer_done = 1'b0;
        end
        if (timeouts == 0)
            wait_finish(1'b1);
        if (timeouts == 0 && (seen != target || pending != 0))
        begin
            run_errors = run_errors + 1;
            $display("[ERROR] %0t: at finish %0d records were pushed, %0d expected, %0d pending",
                     $time, seen, target, pending);
        end
    endtask

    task automatic report_and_finish();
        $display("checker errors %0d, run errors %0d, timeouts %0d, records %0d",
                 chk_errors, run_errors, timeouts, seen);
        if (chk_errors == 0 && run_errors == 0 && timeouts == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    endtask

    initial
    begin
        clk          = 1'b0;
        reset        = 1'b1;
        i_start      = 1'b0;
        i_table_base = '0;
        i_cfg_data   = '0;
        i_data       = '0;
        i_stopin     = 1'b0;
        i_layer_done = 1'b0;
        rng          = SEED;
        stall_rng    = SEED;
        stall_on     = 1'b0;
        run_errors   = 0;
        timeouts     = 0;
        for (int a = 0; a < 2**DATA_ADDR_W; a++)
            dmem[a] = IN_W'(next_rand());
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        if (o_finish !== 1'b0)
        begin
            run_errors = run_errors + 1;
            $display("[ERROR] %0t: o_finish is not low after reset", $time);
        end
        stall_on = 1'b1;
        run_tables(17'h00100);
        if (timeouts == 0)
            run_tables(17'h08000);
        report_and_finish();
    end

endmodule

`default_nettype wire

//--- compile.f
nn_cfg_pkg.sv
nn_operand_pkg.sv
fetch_sequencer.sv
operand_gather.sv
operand_queue.sv
neuron_fetch_top.sv
tb_operand_checker.sv
tb_neuron_fetch.sv
